/* compile.f */
src/vram_pkg.sv
src/sram_pkg.sv
src/vram_write_fifo.sv
src/pixel_stage.sv
src/sram_sequencer.sv
src/sio_shifter.sv
src/spi_video_ram.sv
verif/spi_video_ram_checker.sv
verif/tb_spi_video_ram.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with verilator, pass decided from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_spi_video_ram -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* src/pixel_stage.sv */
`timescale 1ns/1ns

module pixel_stage
    import vram_pkg::*;
    import sram_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          display_active_i,
    input  logic [POS_WIDTH-1:0]          hpos_i,
    input  logic [POS_WIDTH-1:0]          vpos_i,
    input  logic                          line_trigger_i,
    input  logic                          initialized_i,
    input  seq_state_t                    state_i,
    input  logic [3:0]                    nibble_i,
    input  logic                          nibble_valid_i,
    output logic                          read_request_o,
    output logic [SRAM_ADDRESS_WIDTH-1:0] line_address_o,
    output logic                          pixel_o
);

    logic                 in_line;
    logic                 in_col;
    logic                 new_request;
    logic [POS_WIDTH-1:0] line_num;
    logic [3:0]           pixel_nibble;
    logic [1:0]           pixel_index;

    assign in_line = (vpos_i >= POS_WIDTH'(SCREEN_V_OFFSET)) &&
                     (vpos_i < POS_WIDTH'(SCREEN_V_OFFSET + SCREEN_HEIGHT));
    assign in_col  = (hpos_i >= POS_WIDTH'(SCREEN_H_OFFSET)) &&
                     (hpos_i < POS_WIDTH'(SCREEN_H_OFFSET + SCREEN_WIDTH));

    assign new_request = line_trigger_i && in_line && initialized_i;
    assign line_num    = vpos_i - POS_WIDTH'(SCREEN_V_OFFSET);

    // request held until the sequencer takes it
    always_ff @(posedge clk) begin
        if (reset) begin
            read_request_o <= 1'b0;
        end else if (state_i == ST_READ) begin
            read_request_o <= 1'b0;
        end else if (new_request) begin
            read_request_o <= 1'b1;
        end
    end

    // line address frozen at the trigger
    always_ff @(posedge clk) begin
        if (new_request && state_i != ST_READ) begin
            line_address_o <= SRAM_ADDRESS_WIDTH'(line_num) << LINE_SHIFT;
        end
        if (nibble_valid_i) begin
            pixel_nibble <= nibble_i;
        end
    end

    // leftmost pixel of a nibble is on sio3
    assign pixel_index = ~hpos_i[1:0];
    assign pixel_o = display_active_i && in_line && in_col && !pixel_nibble[pixel_index];

endmodule

/* src/sio_shifter.sv */
`timescale 1ns/1ns

module sio_shifter
    import vram_pkg::*;
    import sram_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  seq_state_t                    state_i,
    input  logic [SCK_COUNT_WIDTH-1:0]    sck_count_i,
    input  logic                          sck_rise_i,
    input  logic                          sck_fall_i,
    input  logic [SRAM_ADDRESS_WIDTH-1:0] line_address_i,
    input  logic [VRAM_ADDRESS_WIDTH-1:0] fifo_address_i,
    input  logic [WORD_WIDTH-1:0]         fifo_data_i,
    input  logic [3:0]                    sram_sio_i,
    output logic [3:0]                    sram_sio_o,
    output logic                          sram_sio_oe_o,
    output logic [3:0]                    nibble_o,
    output logic                          nibble_valid_o
);

    logic [BUFFER_WIDTH-1:0]       buffer;
    io_mode_t                      io_mode;
    logic                          was_idle;
    logic                          frame_start;
    logic                          read_capture;
    logic [7:0]                    opcode;
    logic [VRAM_ADDRESS_WIDTH-1:0] word_address;
    logic [WORD_WIDTH-1:0]         word_data;
    logic [WORD_WIDTH-1:0]         word_reversed;

    assign frame_start  = was_idle && (state_i != ST_IDLE);
    assign read_capture = sck_fall_i && (state_i == ST_READ) &&
                          (sck_count_i >= SCK_COUNT_WIDTH'(READ_DATA_START)) &&
                          (sck_count_i < SCK_COUNT_WIDTH'(READ_TOTAL_CLKS));

    always_comb begin
        case (state_i)
            ST_RESET_IO:   opcode = INS_RSTIO;
            ST_ENTER_QUAD: opcode = INS_EQIO;
            ST_READ:       opcode = INS_READ;
            default:       opcode = INS_WRITE;
        endcase
    end

    // cpu keeps its first pixel in bit 0
    always_comb begin
        for (int i = 0; i < WORD_WIDTH; i++) begin
            word_reversed[i] = word_data[WORD_WIDTH-1-i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            was_idle <= 1'b1;
            io_mode  <= IO_SPI;
            buffer   <= '0;
        end else begin
            was_idle <= (state_i == ST_IDLE);
            if (frame_start) begin
                buffer  <= {opcode, {(BUFFER_WIDTH-8){1'b0}}};
                io_mode <= (state_i inside {ST_RESET_IO, ST_ENTER_QUAD}) ? IO_SPI : IO_SQI;
            end else if (sck_rise_i) begin
                // new section or next bits, one clk after the rise
                if ((state_i == ST_READ) && (sck_count_i == SCK_COUNT_WIDTH'(INSTR_CLKS))) begin
                    buffer <= line_address_i;
                end else if ((state_i == ST_WRITE) &&
                             (sck_count_i == SCK_COUNT_WIDTH'(INSTR_CLKS))) begin
                    // two bytes per cpu word
                    buffer <= BUFFER_WIDTH'({word_address, 1'b0});
                end else if ((state_i == ST_WRITE) &&
                             (sck_count_i == SCK_COUNT_WIDTH'(INSTR_CLKS + ADDR_CLKS))) begin
                    buffer <= {word_reversed, {(BUFFER_WIDTH-WORD_WIDTH){1'b0}}};
                end else if (io_mode == IO_SQI) begin
                    buffer <= buffer << 4;
                end else begin
                    buffer <= buffer << 1;
                end
            end
        end
    end

    // popped entry, kept for the whole write frame
    always_ff @(posedge clk) begin
        if (frame_start && state_i == ST_WRITE) begin
            word_address <= fifo_address_i;
            word_data    <= fifo_data_i;
        end
        if (read_capture) begin
            nibble_o <= sram_sio_i;
        end
    end

    // sram owns the bus during read data
    always_ff @(posedge clk) begin
        if (reset) begin
            sram_sio_oe_o  <= 1'b1;
            nibble_valid_o <= 1'b0;
        end else begin
            sram_sio_oe_o  <= !((state_i == ST_READ) &&
                               (sck_count_i >= SCK_COUNT_WIDTH'(READ_DATA_START)));
            nibble_valid_o <= read_capture;
        end
    end

    // spi mode keeps hold_n high on sio3
    assign sram_sio_o = (io_mode == IO_SQI) ? buffer[BUFFER_WIDTH-1 -: 4]
                                            : {1'b1, 2'b00, buffer[BUFFER_WIDTH-1]};

endmodule

/* src/spi_video_ram.sv */
`timescale 1ns/1ns

module spi_video_ram
    import vram_pkg::*;
    import sram_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          hack_write_i,
    input  logic [VRAM_ADDRESS_WIDTH-1:0] hack_address_i,
    input  logic [WORD_WIDTH-1:0]         hack_data_i,
    input  logic                          display_active_i,
    input  logic [POS_WIDTH-1:0]          hpos_i,
    input  logic [POS_WIDTH-1:0]          vpos_i,
    input  logic                          line_trigger_i,
    input  logic [3:0]                    sram_sio_i,
    output logic                          sram_cs_n_o,
    output logic                          sram_sck_o,
    output logic                          sram_sio_oe_o,
    output logic [3:0]                    sram_sio_o,
    output logic                          pixel_o,
    output logic                          initialized_o
);

    logic                          push;
    logic [VRAM_ADDRESS_WIDTH-1:0] push_address;
    logic [WORD_WIDTH-1:0]         push_data;
    logic                          fifo_pop;
    logic                          fifo_full;
    logic                          fifo_empty;
    logic [VRAM_ADDRESS_WIDTH-1:0] fifo_address;
    logic [WORD_WIDTH-1:0]         fifo_data;
    seq_state_t                    state;
    logic [SCK_COUNT_WIDTH-1:0]    sck_count;
    logic                          sck_rise;
    logic                          sck_fall;
    logic                          read_request;
    logic [SRAM_ADDRESS_WIDTH-1:0] line_address;
    logic [3:0]                    nibble;
    logic                          nibble_valid;

    // cpu write strobe registered into a push
    always_ff @(posedge clk) begin
        if (reset) begin
            push <= 1'b0;
        end else begin
            push <= hack_write_i && !fifo_full;
        end
    end

    always_ff @(posedge clk) begin
        push_address <= hack_address_i;
        push_data    <= hack_data_i;
    end

    vram_write_fifo i_fifo (
        .clk(clk), .reset(reset),
        .push_i(push), .push_address_i(push_address), .push_data_i(push_data),
        .pop_i(fifo_pop), .pop_address_o(fifo_address), .pop_data_o(fifo_data),
        .full_o(fifo_full), .empty_o(fifo_empty)
    );

    sram_sequencer i_sequencer (
        .clk(clk), .reset(reset),
        .fifo_empty_i(fifo_empty), .read_request_i(read_request),
        .state_o(state), .sck_count_o(sck_count), .sck_rise_o(sck_rise), .sck_fall_o(sck_fall),
        .pop_o(fifo_pop), .sram_cs_n_o(sram_cs_n_o), .sram_sck_o(sram_sck_o),
        .initialized_o(initialized_o)
    );

    sio_shifter i_shifter (
        .clk(clk), .reset(reset),
        .state_i(state), .sck_count_i(sck_count), .sck_rise_i(sck_rise), .sck_fall_i(sck_fall),
        .line_address_i(line_address), .fifo_address_i(fifo_address), .fifo_data_i(fifo_data),
        .sram_sio_i(sram_sio_i), .sram_sio_o(sram_sio_o), .sram_sio_oe_o(sram_sio_oe_o),
        .nibble_o(nibble), .nibble_valid_o(nibble_valid)
    );

    pixel_stage i_pixel (
        .clk(clk), .reset(reset),
        .display_active_i(display_active_i), .hpos_i(hpos_i), .vpos_i(vpos_i),
        .line_trigger_i(line_trigger_i), .initialized_i(initialized_o), .state_i(state),
        .nibble_i(nibble), .nibble_valid_i(nibble_valid),
        .read_request_o(read_request), .line_address_o(line_address), .pixel_o(pixel_o)
    );

endmodule

/* src/sram_pkg.sv */
package sram_pkg;

    // 23LC1024 opcodes
    localparam logic [7:0] INS_READ = 8'h03;
    localparam logic [7:0] INS_WRITE = 8'h02;
    localparam logic [7:0] INS_EQIO = 8'h38;
    localparam logic [7:0] INS_RSTIO = 8'hff;

    localparam int SRAM_ADDRESS_WIDTH = 24;
    localparam int BUFFER_WIDTH = 24;

    // frame sections, in sck cycles
    localparam int INSTR_CLKS = 2;
    localparam int ADDR_CLKS = 6;
    localparam int DUMMY_CLKS = 2;
    localparam int SPI_CMD_CLKS = 8;
    localparam int WRITE_DATA_CLKS = 4;
    localparam int WRITE_TOTAL_CLKS = INSTR_CLKS + ADDR_CLKS + WRITE_DATA_CLKS;
    localparam int READ_DATA_START = INSTR_CLKS + ADDR_CLKS + DUMMY_CLKS;
    localparam int READ_TOTAL_CLKS = READ_DATA_START + vram_pkg::NIBBLES_PER_LINE;
    localparam int SCK_COUNT_WIDTH = $clog2(READ_TOTAL_CLKS + 1);

    // single bit spi or four bit sqi on the sio lines
    typedef enum logic {IO_SPI, IO_SQI} io_mode_t;

    typedef enum logic [2:0] {
        ST_RESET_IO   = 3'd0,
        ST_ENTER_QUAD = 3'd1,
        ST_IDLE       = 3'd2,
        ST_READ       = 3'd3,
        ST_WRITE      = 3'd4
    } seq_state_t;

endpackage

/* src/sram_sequencer.sv */
`timescale 1ns/1ns

module sram_sequencer
    import sram_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fifo_empty_i,
    input  logic                       read_request_i,
    output seq_state_t                 state_o,
    output logic [SCK_COUNT_WIDTH-1:0] sck_count_o,
    output logic                       sck_rise_o,
    output logic                       sck_fall_o,
    output logic                       pop_o,
    output logic                       sram_cs_n_o,
    output logic                       sram_sck_o,
    output logic                       initialized_o
);

    logic [SCK_COUNT_WIDTH-1:0] frame_clks;
    logic                       sck_run;
    logic                       frame_done;

    // frame length of the current state
    always_comb begin
        case (state_o)
            ST_READ:  frame_clks = SCK_COUNT_WIDTH'(READ_TOTAL_CLKS);
            ST_WRITE: frame_clks = SCK_COUNT_WIDTH'(WRITE_TOTAL_CLKS);
            default:  frame_clks = SCK_COUNT_WIDTH'(SPI_CMD_CLKS);
        endcase
    end

    // sck only toggles while the chip is selected
    assign sck_run = !sram_cs_n_o && (state_o != ST_IDLE);

    // last rise done and sck back low
    assign frame_done = sck_run && !sram_sck_o && (sck_count_o == frame_clks);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_o       <= ST_RESET_IO;
            initialized_o <= 1'b0;
            pop_o         <= 1'b0;
        end else begin
            pop_o <= 1'b0;
            case (state_o)
                ST_IDLE: begin
                    // reads only with no writes queued
                    if (!initialized_o) begin
                        state_o <= ST_ENTER_QUAD;
                    end else if (read_request_i && fifo_empty_i) begin
                        state_o <= ST_READ;
                    end else if (!fifo_empty_i) begin
                        state_o <= ST_WRITE;
                        pop_o   <= 1'b1;
                    end
                end
                ST_ENTER_QUAD: begin
                    if (frame_done) begin
                        state_o       <= ST_IDLE;
                        initialized_o <= 1'b1;
                    end
                end
                default: begin
                    if (frame_done) begin
                        state_o <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // chip select follows the state one cycle late
    always_ff @(posedge clk) begin
        if (reset) begin
            sram_cs_n_o <= 1'b1;
        end else begin
            sram_cs_n_o <= (state_o == ST_IDLE);
        end
    end

    // sck at half the clk rate, edges counted on the rise
    always_ff @(posedge clk) begin
        if (reset) begin
            sram_sck_o  <= 1'b0;
            sck_count_o <= '0;
            sck_rise_o  <= 1'b0;
            sck_fall_o  <= 1'b0;
        end else begin
            sck_rise_o <= 1'b0;
            sck_fall_o <= 1'b0;
            if (!sck_run) begin
                sram_sck_o  <= 1'b0;
                sck_count_o <= '0;
            end else if (sram_sck_o) begin
                sram_sck_o <= 1'b0;
                sck_fall_o <= 1'b1;
            end else if (sck_count_o != frame_clks) begin
                sram_sck_o  <= 1'b1;
                sck_rise_o  <= 1'b1;
                sck_count_o <= sck_count_o + 1'b1;
            end
        end
    end

endmodule

/* src/vram_pkg.sv */
package vram_pkg;

    // cpu word and word address
    localparam int WORD_WIDTH = 16;
    localparam int VRAM_ADDRESS_WIDTH = 13;

    // visible screen in pixels
    localparam int SCREEN_WIDTH = 512;
    localparam int SCREEN_HEIGHT = 256;

    // top left corner of the screen window on the display
    localparam int SCREEN_H_OFFSET = 64;
    localparam int SCREEN_V_OFFSET = 112;

    // display counters
    localparam int POS_WIDTH = 10;

    // one bit per pixel, so a line is SCREEN_WIDTH/8 bytes
    localparam int LINE_SHIFT = $clog2(SCREEN_WIDTH / 8);

    // four pixels per sram nibble
    localparam int NIBBLES_PER_LINE = SCREEN_WIDTH / 4;

    // pending cpu writes
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

endpackage

/* src/vram_write_fifo.sv */
`timescale 1ns/1ns

module vram_write_fifo
    import vram_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          push_i,
    input  logic [VRAM_ADDRESS_WIDTH-1:0] push_address_i,
    input  logic [WORD_WIDTH-1:0]         push_data_i,
    input  logic                          pop_i,
    output logic [VRAM_ADDRESS_WIDTH-1:0] pop_address_o,
    output logic [WORD_WIDTH-1:0]         pop_data_o,
    output logic                          full_o,
    output logic                          empty_o
);

    logic [VRAM_ADDRESS_WIDTH-1:0] address_mem [FIFO_DEPTH];
    logic [WORD_WIDTH-1:0]         data_mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0]     wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0]     rd_ptr;
    logic [FIFO_PTR_WIDTH:0]       count;
    logic                          do_push;
    logic                          do_pop;

    // a push into a full queue is lost
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o  = (count == (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH));
    assign empty_o = (count == '0);

    // head entry
    assign pop_address_o = address_mem[rd_ptr];
    assign pop_data_o    = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            address_mem[wr_ptr] <= push_address_i;
            data_mem[wr_ptr]    <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // pointers wrap on their own, depth is a power of two
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verif/spi_video_ram_checker.sv */
`timescale 1ns/1ns

module spi_video_ram_checker (
    input logic clk,
    input logic reset,
    input logic sram_cs_n_i,
    input logic sram_sck_i,
    input logic sram_sio_oe_i,
    input logic initialized_i
);

    // sck idles low between frames
    sck_low_when_deselected: assert property (
        @(posedge clk) disable iff (reset) sram_cs_n_i |-> !sram_sck_i
    ) else $error("sck high while chip select is high");

    // controller owns the sio lines outside a frame
    oe_high_when_deselected: assert property (
        @(posedge clk) disable iff (reset) sram_cs_n_i |-> sram_sio_oe_i
    ) else $error("sio output enable low while chip select is high");

    cs_high_in_reset: assert property (
        @(posedge clk) reset |=> sram_cs_n_i
    ) else $error("chip select low during reset");

    // once the sram is in quad mode it stays there
    initialized_sticky: assert property (
        @(posedge clk) disable iff (reset) !$fell(initialized_i)
    ) else $error("initialized_o fell outside reset");

endmodule

/* verif/tb_spi_video_ram.sv */
`timescale 1ns/1ns

module tb_spi_video_ram
    import vram_pkg::*;
    import sram_pkg::*;
();

    logic                          clk;
    logic                          reset;
    logic                          hack_write_i;
    logic [VRAM_ADDRESS_WIDTH-1:0] hack_address_i;
    logic [WORD_WIDTH-1:0]         hack_data_i;
    logic                          display_active_i;
    logic [POS_WIDTH-1:0]          hpos_i;
    logic [POS_WIDTH-1:0]          vpos_i;
    logic                          line_trigger_i;
    logic [3:0]                    sram_sio_i;
    logic                          sram_cs_n_o;
    logic                          sram_sck_o;
    logic                          sram_sio_oe_o;
    logic [3:0]                    sram_sio_o;
    logic                          pixel_o;
    logic                          initialized_o;

    logic [31:0] lfsr_state = 32'h106c_bbc5;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          pixel_checks = 0;
    int          next_frame = 0;
    // one entry per completed frame
    int          frame_len_q[$];
    logic [47:0] frame_bits_q[$];
    logic [7:0]  frame_spi_q[$];
    bit          frame_sio3_q[$];
    bit          in_frame = 0;
    int          nib_count;
    logic [47:0] nib_bits;
    logic [47:0] monitor_bits;
    logic [7:0]  spi_byte;
    bit          sio3_high;
    // nibble model of the sram read data
    int          drive_count = 0;
    bit          sck_seen_high = 0;
    logic [3:0]  last_nibble;
    logic [3:0]  prev_nibble;
    logic [VRAM_ADDRESS_WIDTH-1:0] exp_addr [8];
    logic [WORD_WIDTH-1:0]         exp_data [8];

    spi_video_ram i_dut (.*);

    bind spi_video_ram spi_video_ram_checker i_checker (
        .clk(clk), .reset(reset), .sram_cs_n_i(sram_cs_n_o), .sram_sck_i(sram_sck_o),
        .sram_sio_oe_i(sram_sio_oe_o), .initialized_i(initialized_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        assert (cond) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: no %s within the cycle limit", what);
        $display("Test failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("%s: %s", name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    task automatic wait_frames(input int n);
        int t;
        t = 0;
        while (frame_len_q.size() < n) begin
            @(posedge clk);
            #1;
            t++;
            if (t > 5000) begin
                timeout_fail("sram frame");
            end
        end
    endtask

    // n back to back cpu writes with an optional line trigger on the last one
    task automatic issue_writes(input int n, input bit trigger);
        logic [15:0] r;
        for (int i = 0; i < n; i++) begin
            take_bits(13, r);
            exp_addr[i] = r[12:0];
            take_bits(16, r);
            exp_data[i] = r;
            hack_write_i = 1'b1;
            hack_address_i = exp_addr[i];
            hack_data_i = exp_data[i];
            line_trigger_i = trigger && (i == n - 1);
            @(posedge clk);
            #1;
        end
        hack_write_i = 1'b0;
        line_trigger_i = 1'b0;
    endtask

    task automatic check_write_frame(input logic [12:0] a, input logic [15:0] d);
        logic [15:0] rev;
        logic [23:0] byte_addr;
        logic [47:0] exp_bits;
        for (int i = 0; i < 16; i++) begin
            rev[i] = d[15-i];
        end
        byte_addr = 24'(a) << 1;
        exp_bits = {INS_WRITE, byte_addr, rev};
        check_true(frame_len_q[next_frame] == INSTR_CLKS + ADDR_CLKS + WRITE_DATA_CLKS,
                   $sformatf("write frame %0d has %0d sck", next_frame,
                             frame_len_q[next_frame]));
        check_true(frame_bits_q[next_frame] == exp_bits,
                   $sformatf("write frame %0d carries %h, expected %h", next_frame,
                             frame_bits_q[next_frame], exp_bits));
        next_frame++;
    endtask

    task automatic check_read_frame(input int line);
        logic [31:0] exp_head;
        exp_head = {INS_READ, 24'(line * 64)};
        check_true(frame_len_q[next_frame] == 10 + NIBBLES_PER_LINE,
                   $sformatf("read frame %0d has %0d sck", next_frame,
                             frame_len_q[next_frame]));
        check_true(frame_bits_q[next_frame][47:16] == exp_head,
                   $sformatf("read frame %0d header %h, expected %h", next_frame,
                             frame_bits_q[next_frame][47:16], exp_head));
        next_frame++;
    endtask

    // display counters and sram read data move 1 ns after the edge
    always @(posedge clk) begin
        #1;
        hpos_i = (hpos_i == 10'd799) ? 10'd0 : hpos_i + 10'd1;
        display_active_i = (hpos_i < 10'd640);
        if (sram_cs_n_o) begin
            drive_count = 0;
        end else if (!sram_sio_oe_o && !sram_sck_o && sck_seen_high) begin
            take_bits(4, nib_bits[15:0]);
            prev_nibble = last_nibble;
            last_nibble = nib_bits[3:0];
            sram_sio_i = nib_bits[3:0];
            drive_count++;
        end
        sck_seen_high = sram_sck_o;
    end

    // frame monitor samples sio while sck is high
    always @(negedge clk) begin
        if (!sram_cs_n_o) begin
            if (!in_frame) begin
                in_frame = 1;
                nib_count = 0;
                spi_byte = '0;
                monitor_bits = '0;
                sio3_high = 1;
            end
            if (sram_sck_o) begin
                nib_count++;
                if (nib_count <= 12) begin
                    monitor_bits = {monitor_bits[43:0], sram_sio_o};
                end
                if (nib_count <= 8) begin
                    spi_byte = {spi_byte[6:0], sram_sio_o[0]};
                end
                if (!sram_sio_o[3]) begin
                    sio3_high = 0;
                end
            end
        end else if (in_frame) begin
            in_frame = 0;
            frame_len_q.push_back(nib_count);
            frame_bits_q.push_back(monitor_bits);
            frame_spi_q.push_back(spi_byte);
            frame_sio3_q.push_back(sio3_high);
        end
    end

    // pixel output against the nibble driven before the latest one
    always @(negedge clk) begin
        bit exp_pixel;
        bit in_window;
        if (!sram_cs_n_o && !sram_sio_oe_o && !sram_sck_o && drive_count >= 2) begin
            in_window = (hpos_i >= SCREEN_H_OFFSET) && (hpos_i < SCREEN_H_OFFSET + SCREEN_WIDTH)
                     && (vpos_i >= SCREEN_V_OFFSET) && (vpos_i < SCREEN_V_OFFSET + SCREEN_HEIGHT);
            exp_pixel = display_active_i && in_window && !prev_nibble[3 - hpos_i[1:0]];
            pixel_checks++;
            check_true(pixel_o == exp_pixel,
                       $sformatf("pixel %b at hpos %0d, expected %b", pixel_o, hpos_i, exp_pixel));
        end
    end

    initial begin
        int snap;
        int t;
        reset = 1'b1;
        hack_write_i = 1'b0;
        hack_address_i = '0;
        hack_data_i = '0;
        display_active_i = 1'b0;
        hpos_i = '0;
        vpos_i = POS_WIDTH'(SCREEN_V_OFFSET + 5);
        line_trigger_i = 1'b0;
        sram_sio_i = 4'h0;
        monitor_bits = '0;

        snap = errors;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            check_true(sram_cs_n_o && sram_sio_oe_o && !initialized_o,
                       "chip select, output enable or initialized wrong in reset");
        end
        reset = 1'b0;
        wait_frames(1);
        check_true(!initialized_o, "initialized_o high after the first frame");
        wait_frames(2);
        for (int f = 0; f < 2; f++) begin
            check_true(frame_len_q[f] == SPI_CMD_CLKS, $sformatf("spi frame %0d length", f));
            check_true(frame_sio3_q[f], $sformatf("sio3 low in spi frame %0d", f));
        end
        check_true(frame_spi_q[0] == INS_RSTIO,
                   $sformatf("first opcode %h, expected %h", frame_spi_q[0], INS_RSTIO));
        check_true(frame_spi_q[1] == INS_EQIO,
                   $sformatf("second opcode %h, expected %h", frame_spi_q[1], INS_EQIO));
        next_frame = 2;
        t = 0;
        while (!initialized_o) begin
            @(posedge clk);
            #1;
            t++;
            if (t > 100) begin
                timeout_fail("rise of initialized_o");
            end
        end
        report_test("reset and quad entry", snap);

        snap = errors;
        issue_writes(1, 0);
        wait_frames(next_frame + 1);
        check_write_frame(exp_addr[0], exp_data[0]);
        report_test("single write frame", snap);

        // the read waits until both writes have gone out
        snap = errors;
        issue_writes(2, 1);
        // below the screen window while this line is read
        vpos_i = POS_WIDTH'(SCREEN_V_OFFSET + SCREEN_HEIGHT + 8);
        wait_frames(next_frame + 3);
        check_write_frame(exp_addr[0], exp_data[0]);
        check_write_frame(exp_addr[1], exp_data[1]);
        check_read_frame(5);
        report_test("writes before line read", snap);

        snap = errors;
        check_true(pixel_checks > 0, "no pixel was checked during read data");
        report_test("pixel output", snap);

        snap = errors;
        vpos_i = POS_WIDTH'(SCREEN_V_OFFSET + 200);
        line_trigger_i = 1'b1;
        @(posedge clk);
        #1;
        line_trigger_i = 1'b0;
        t = 0;
        while (sram_sio_oe_o) begin
            @(posedge clk);
            #1;
            t++;
            if (t > 1000) begin
                timeout_fail("read data phase");
            end
        end
        issue_writes(5, 0);
        wait_frames(next_frame + 1 + FIFO_DEPTH);
        check_read_frame(200);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            check_write_frame(exp_addr[i], exp_data[i]);
        end
        // the fifth write was dropped and the bus stays quiet
        repeat (300) @(posedge clk);
        check_true(frame_len_q.size() == next_frame, "extra frame after a full fifo");
        report_test("full fifo drops a write", snap);

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
